//--- hdl/mem_pkg.sv
package mem_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;
	// byte offset bits within one word
	localparam int OFFS_W = $clog2(STRB_W);

	// sram geometry
	localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
	localparam int MEM_WORDS = 512;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);

	// response codes, axi encoding
	localparam logic [1:0] RESP_OKAY = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// read address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} ar_req_t;

	// read data channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
	} r_rsp_t;

	// write address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} aw_req_t;

	// write data channel, one strobe bit per byte lane
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} w_req_t;

	// write response channel
	typedef struct packed {
		logic [1:0] resp;
	} b_rsp_t;

endpackage

//--- hdl/axi_sram.sv
module axi_sram (
	input logic clk,
	input logic rst,
	// read address
	input mem_pkg::ar_req_t ar,
	input logic arvalid,
	output logic arready,
	// read data
	output mem_pkg::r_rsp_t r,
	output logic rvalid,
	input logic rready,
	// write address
	input mem_pkg::aw_req_t aw,
	input logic awvalid,
	output logic awready,
	// write data
	input mem_pkg::w_req_t w,
	input logic wvalid,
	output logic wready,
	// write response
	output mem_pkg::b_rsp_t b,
	output logic bvalid,
	input logic bready
);
	import mem_pkg::*;

	// idle, or holding a response until the master takes it
	typedef enum logic {
		ST_IDLE,
		ST_PEND
	} state_t;

	// word array
	logic [DATA_W-1:0] mem [MEM_WORDS];

	state_t rd_state;
	state_t wr_state;

	logic [ADDR_W-1:0] rd_offs;
	logic [ADDR_W-1:0] wr_offs;
	logic rd_hit;
	logic wr_hit;
	logic [MEM_IDX_W-1:0] rd_idx;
	logic [MEM_IDX_W-1:0] wr_idx;
	logic rd_take;
	logic wr_take;

	// address decode
	// below base wraps to a huge offset, so one check covers both ends
	assign rd_offs = ar.addr - MEM_BASE;
	assign wr_offs = aw.addr - MEM_BASE;
	assign rd_hit = (rd_offs[ADDR_W-1:MEM_IDX_W+OFFS_W] == '0);
	assign wr_hit = (wr_offs[ADDR_W-1:MEM_IDX_W+OFFS_W] == '0);
	// low offset bits dropped, word addressed
	assign rd_idx = rd_offs[OFFS_W +: MEM_IDX_W];
	assign wr_idx = wr_offs[OFFS_W +: MEM_IDX_W];

	// read side
	// one read in flight, address accepted only while idle
	assign arready = (rd_state == ST_IDLE);
	assign rd_take = arvalid && arready;
	assign rvalid = (rd_state == ST_PEND);

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= ST_IDLE;
		end else begin
			case (rd_state)
				ST_IDLE: begin
					if (arvalid) begin
						rd_state <= ST_PEND;
					end
				end
				ST_PEND: begin
					// arready comes back on the same edge
					if (rready) begin
						rd_state <= ST_IDLE;
					end
				end
				default: begin
					rd_state <= ST_IDLE;
				end
			endcase
		end
	end

	// response word, held while pending
	always_ff @(posedge clk) begin
		if (rd_take) begin
			if (rd_hit) begin
				r.data <= mem[rd_idx];
				r.resp <= RESP_OKAY;
			end else begin
				// out of range reads back zero
				r.data <= '0;
				r.resp <= RESP_SLVERR;
			end
		end
	end

	// write side
	// aw and w always taken together
	assign wr_take = awvalid && wvalid && (wr_state == ST_IDLE);
	assign awready = wr_take;
	assign wready = wr_take;
	assign bvalid = (wr_state == ST_PEND);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= ST_IDLE;
		end else begin
			case (wr_state)
				ST_IDLE: begin
					if (wr_take) begin
						wr_state <= ST_PEND;
					end
				end
				ST_PEND: begin
					if (bready) begin
						wr_state <= ST_IDLE;
					end
				end
				default: begin
					wr_state <= ST_IDLE;
				end
			endcase
		end
	end

	// byte lane merge
	// a read on the next edge already sees this
	always_ff @(posedge clk) begin
		if (wr_take && wr_hit) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (w.strb[i]) begin
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
	end

	// error on miss, array untouched
	always_ff @(posedge clk) begin
		if (wr_take) begin
			b.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

//--- hdl/axi_read_arbiter.sv
module axi_read_arbiter (
	input logic clk,
	input logic rst,
	// fetch port, read only
	input mem_pkg::ar_req_t if_ar,
	input logic if_arvalid,
	output logic if_arready,
	output mem_pkg::r_rsp_t if_r,
	output logic if_rvalid,
	input logic if_rready,
	// data port, read
	input mem_pkg::ar_req_t d_ar,
	input logic d_arvalid,
	output logic d_arready,
	output mem_pkg::r_rsp_t d_r,
	output logic d_rvalid,
	input logic d_rready,
	// data port, write
	input mem_pkg::aw_req_t d_aw,
	input logic d_awvalid,
	output logic d_awready,
	input mem_pkg::w_req_t d_w,
	input logic d_wvalid,
	output logic d_wready,
	output mem_pkg::b_rsp_t d_b,
	output logic d_bvalid,
	input logic d_bready,
	// slave side
	output mem_pkg::ar_req_t s_ar,
	output logic s_arvalid,
	input logic s_arready,
	input mem_pkg::r_rsp_t s_r,
	input logic s_rvalid,
	output logic s_rready,
	output mem_pkg::aw_req_t s_aw,
	output logic s_awvalid,
	input logic s_awready,
	output mem_pkg::w_req_t s_w,
	output logic s_wvalid,
	input logic s_wready,
	input mem_pkg::b_rsp_t s_b,
	input logic s_bvalid,
	output logic s_bready
);
	import mem_pkg::*;

	// last grant went to the data port
	logic last_d;
	// response still owed to owner
	logic locked;
	// owner of the pending read, 1 for data port
	logic owner;
	logic grant_d;
	ar_req_t win_ar;

	// round robin
	// on a tie the port not granted last wins
	// reset leaves last_d set so fetch goes first
	assign grant_d = d_arvalid && (!if_arvalid || !last_d);
	assign win_ar = grant_d ? d_ar : if_ar;

	// address steering, same cycle
	// nothing forwarded while locked
	assign s_ar = win_ar;
	assign s_arvalid = !locked && (if_arvalid || d_arvalid);
	// loser sees arready low
	assign if_arready = !locked && !grant_d && s_arready;
	assign d_arready = !locked && grant_d && s_arready;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_d <= 1'b1;
			locked <= 1'b0;
			owner <= 1'b0;
		end else if (!locked) begin
			// address taken, hold owner until r handshake
			if (s_arvalid && s_arready) begin
				locked <= 1'b1;
				owner <= grant_d;
				last_d <= grant_d;
			end
		end else if (s_rvalid && s_rready) begin
			locked <= 1'b0;
		end
	end

	// response steering
	// payload shared, only the owner sees rvalid
	assign if_r = s_r;
	assign d_r = s_r;
	assign if_rvalid = locked && !owner && s_rvalid;
	assign d_rvalid = locked && owner && s_rvalid;
	assign s_rready = locked && (owner ? d_rready : if_rready);

	// only the data port writes, straight through
	assign s_aw = d_aw;
	assign s_awvalid = d_awvalid;
	assign d_awready = s_awready;
	assign s_w = d_w;
	assign s_wvalid = d_wvalid;
	assign d_wready = s_wready;
	assign d_b = s_b;
	assign d_bvalid = s_bvalid;
	assign s_bready = d_bready;

endmodule

//--- hdl/axi_sram_subsys_top.sv
module axi_sram_subsys_top (
	input logic clk,
	input logic rst,
	// fetch port
	input mem_pkg::ar_req_t if_ar,
	input logic if_arvalid,
	output logic if_arready,
	output mem_pkg::r_rsp_t if_r,
	output logic if_rvalid,
	input logic if_rready,
	// data port
	input mem_pkg::ar_req_t d_ar,
	input logic d_arvalid,
	output logic d_arready,
	output mem_pkg::r_rsp_t d_r,
	output logic d_rvalid,
	input logic d_rready,
	input mem_pkg::aw_req_t d_aw,
	input logic d_awvalid,
	output logic d_awready,
	input mem_pkg::w_req_t d_w,
	input logic d_wvalid,
	output logic d_wready,
	output mem_pkg::b_rsp_t d_b,
	output logic d_bvalid,
	input logic d_bready
);
	import mem_pkg::*;

	// arbiter to sram
	ar_req_t s_ar;
	r_rsp_t s_r;
	aw_req_t s_aw;
	w_req_t s_w;
	b_rsp_t s_b;
	logic s_arvalid;
	logic s_arready;
	logic s_rvalid;
	logic s_rready;
	logic s_awvalid;
	logic s_awready;
	logic s_wvalid;
	logic s_wready;
	logic s_bvalid;
	logic s_bready;

	// port names line up one to one
	axi_read_arbiter u_arb (.*);

	axi_sram u_sram (
		.clk(clk),
		.rst(rst),
		.ar(s_ar),
		.arvalid(s_arvalid),
		.arready(s_arready),
		.r(s_r),
		.rvalid(s_rvalid),
		.rready(s_rready),
		.aw(s_aw),
		.awvalid(s_awvalid),
		.awready(s_awready),
		.w(s_w),
		.wvalid(s_wvalid),
		.wready(s_wready),
		.b(s_b),
		.bvalid(s_bvalid),
		.bready(s_bready)
	);

endmodule

//--- bench/axi_sram_subsys_tb.sv
module axi_sram_subsys_tb;
	import mem_pkg::*;

	logic clk;
	logic rst;
	// fetch port
	ar_req_t if_ar;
	logic if_arvalid;
	logic if_arready;
	r_rsp_t if_r;
	logic if_rvalid;
	logic if_rready;
	// data port
	ar_req_t d_ar;
	logic d_arvalid;
	logic d_arready;
	r_rsp_t d_r;
	logic d_rvalid;
	logic d_rready;
	aw_req_t d_aw;
	logic d_awvalid;
	logic d_awready;
	w_req_t d_w;
	logic d_wvalid;
	logic d_wready;
	b_rsp_t d_b;
	logic d_bvalid;
	logic d_bready;

	// reference memory
	logic [DATA_W-1:0] model [MEM_WORDS];
	// port of each accepted read, 1 for data
	bit grant_order [$];
	logic [31:0] lcg_state;
	int errors;
	int checks;

	axi_sram_subsys_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// random word in the array, low offset bits random too
	function automatic logic [ADDR_W-1:0] rand_addr();
		logic [31:0] v;
		v = next_rand();
		return MEM_BASE + ADDR_W'({v[16 +: MEM_IDX_W], v[2:0]});
	endfunction

	function automatic bit in_range(input logic [ADDR_W-1:0] addr);
		return (addr >= MEM_BASE) && (addr < MEM_BASE + ADDR_W'(8 * MEM_WORDS));
	endfunction

	function automatic logic [MEM_IDX_W-1:0] word_of(input logic [ADDR_W-1:0] addr);
		return MEM_IDX_W'((addr - MEM_BASE) >> 3);
	endfunction

	// channel codes: 0 fetch read, 1 data read, 2 data write
	function automatic string chan_name(input int ch);
		case (ch)
			0: return "fetch read";
			1: return "data read";
			default: return "data write";
		endcase
	endfunction

	function automatic logic ready_of(input int ch);
		case (ch)
			0: return if_arready;
			1: return d_arready;
			default: return d_awready && d_wready;
		endcase
	endfunction

	function automatic logic valid_of(input int ch);
		case (ch)
			0: return if_rvalid;
			1: return d_rvalid;
			default: return d_bvalid;
		endcase
	endfunction

	function automatic logic [71:0] payload_of(input int ch);
		case (ch)
			0: return 72'(if_r);
			1: return 72'(d_r);
			default: return 72'(d_b);
		endcase
	endfunction

	task automatic set_ready(input int ch, input logic v);
		case (ch)
			0: if_rready = v;
			1: d_rready = v;
			default: d_bready = v;
		endcase
	endtask

	task automatic check(input logic [71:0] got, input logic [71:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	// ready sampled mid cycle, away from the edges
	task automatic wait_accept(input int ch, output bit ok);
		int n;
		n = 0;
		@(negedge clk);
		while (!ready_of(ch) && n < 50) begin
			@(negedge clk);
			n++;
		end
		ok = (n < 50);
		if (!ok) begin
			errors++;
			$display("timeout: %s request was never accepted by the DUT", chan_name(ch));
		end
	endtask

	// entered at the negedge right after the accept edge
	task automatic take_response(input int ch, input int hold, input logic [71:0] exp);
		check(72'(valid_of(ch)), 72'(1), {chan_name(ch), " valid one cycle after accept"});
		check(payload_of(ch), exp, {chan_name(ch), " response"});
		repeat (hold) begin
			@(posedge clk);
			#1;
			@(negedge clk);
			check(72'(valid_of(ch)), 72'(1), {chan_name(ch), " valid held while not ready"});
			check(payload_of(ch), exp, {chan_name(ch), " payload stable while not ready"});
			if (ch < 2) begin
				check(72'(if_arready | d_arready), 72'(0), "arready low while read owed");
			end
		end
		if (hold > 0) begin
			@(posedge clk);
			#1;
			set_ready(ch, 1'b1);
			@(negedge clk);
			check(72'(valid_of(ch)), 72'(1), {chan_name(ch), " valid kept until ready"});
		end
		@(posedge clk);
		#1;
		set_ready(ch, 1'b0);
		@(negedge clk);
		check(72'(valid_of(ch)), 72'(0), {chan_name(ch), " response taken once"});
	endtask

	task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb, input int hold);
		logic [DATA_W-1:0] mask;
		logic [1:0] exp_resp;
		bit ok;
		int i;
		exp_resp = in_range(addr) ? RESP_OKAY : RESP_SLVERR;
		@(posedge clk);
		#1;
		d_aw.addr = addr;
		d_w.data = data;
		d_w.strb = strb;
		d_awvalid = 1'b1;
		d_wvalid = 1'b1;
		d_bready = (hold == 0);
		wait_accept(2, ok);
		if (ok && in_range(addr)) begin
			// strobed bytes replace the old ones
			for (i = 0; i < STRB_W; i++) begin
				mask[8*i +: 8] = {8{strb[i]}};
			end
			model[word_of(addr)] = (model[word_of(addr)] & ~mask) | (data & mask);
		end
		@(posedge clk);
		#1;
		d_awvalid = 1'b0;
		d_wvalid = 1'b0;
		@(negedge clk);
		if (ok) begin
			take_response(2, hold, 72'(exp_resp));
		end else begin
			set_ready(2, 1'b0);
		end
	endtask

	task automatic do_read(input bit port, input logic [ADDR_W-1:0] addr, input int hold);
		logic [DATA_W-1:0] exp_data;
		logic [1:0] exp_resp;
		bit ok;
		// out of range reads back zero
		exp_data = in_range(addr) ? model[word_of(addr)] : '0;
		exp_resp = in_range(addr) ? RESP_OKAY : RESP_SLVERR;
		@(posedge clk);
		#1;
		if (port) begin
			d_ar.addr = addr;
			d_arvalid = 1'b1;
		end else begin
			if_ar.addr = addr;
			if_arvalid = 1'b1;
		end
		set_ready(int'(port), hold == 0);
		wait_accept(int'(port), ok);
		if (ok) begin
			grant_order.push_back(port);
		end
		@(posedge clk);
		#1;
		if (port) begin
			d_arvalid = 1'b0;
		end else begin
			if_arvalid = 1'b0;
		end
		@(negedge clk);
		if (ok) begin
			take_response(int'(port), hold, 72'({exp_data, exp_resp}));
		end else begin
			set_ready(int'(port), 1'b0);
		end
	endtask

	// every word gets a pattern built from its own address
	task automatic fill_memory();
		logic [ADDR_W-1:0] addr;
		int i;
		for (i = 0; i < MEM_WORDS; i++) begin
			addr = MEM_BASE + ADDR_W'(8 * i);
			do_write(addr, {~addr, addr}, '1, 0);
		end
	endtask

	task automatic test_write_read();
		logic [ADDR_W-1:0] addr;
		int i;
		for (i = 0; i < 8; i++) begin
			addr = rand_addr();
			do_write(addr, {next_rand(), next_rand()}, '1, 0);
			do_read(1'b0, addr, 0);
			do_read(1'b1, addr, 0);
		end
	endtask

	task automatic test_strobes();
		logic [ADDR_W-1:0] addr;
		logic [31:0] v;
		int i;
		for (i = 0; i < 8; i++) begin
			addr = rand_addr();
			v = next_rand();
			do_write(addr, {next_rand(), next_rand()}, v[15:8], 0);
			do_read(v[0], addr, 0);
		end
	endtask

	task automatic test_out_of_range();
		logic [ADDR_W-1:0] bad [4];
		int i;
		// just below, just past the end, and far off both ways
		bad[0] = MEM_BASE - 32'd8;
		bad[1] = MEM_BASE + ADDR_W'(8 * MEM_WORDS);
		bad[2] = 32'h0000_0040;
		bad[3] = 32'hffff_fff8;
		for (i = 0; i < 4; i++) begin
			do_write(bad[i], {next_rand(), next_rand()}, '1, 0);
			do_read(i[0], bad[i], 0);
		end
		// words a broken decode would alias to
		do_read(1'b1, MEM_BASE, 0);
		do_read(1'b0, MEM_BASE + 32'h40, 0);
		do_read(1'b1, MEM_BASE + ADDR_W'(8 * (MEM_WORDS - 1)), 0);
	endtask

	task automatic test_simultaneous();
		logic [ADDR_W-1:0] a_if;
		logic [ADDR_W-1:0] a_d;
		int i;
		// fresh arbiter, fetch has priority
		@(posedge clk);
		#1;
		reset_dut();
		grant_order.delete();
		for (i = 0; i < 6; i++) begin
			a_if = rand_addr();
			// flip one word bit so the two never match
			a_d = a_if ^ 32'h8;
			// lone fetch read, so the next tie must go to the data port
			if (i == 1) begin
				do_read(1'b0, a_d, 0);
			end
			fork
				do_read(1'b0, a_if, 0);
				do_read(1'b1, a_d, 0);
			join
		end
		check(72'(grant_order.size()), 72'(13), "number of read grants");
		for (i = 0; i < grant_order.size(); i++) begin
			check(72'(grant_order[i]), 72'(i % 2), "grants alternate, fetch first");
		end
	endtask

	task automatic test_backpressure();
		logic [ADDR_W-1:0] addr;
		logic [ADDR_W-1:0] a_if;
		logic [ADDR_W-1:0] a_d;
		logic [31:0] v;
		int i;
		for (i = 0; i < 6; i++) begin
			v = next_rand();
			addr = rand_addr();
			a_if = rand_addr();
			a_d = rand_addr();
			do_write(addr, {next_rand(), next_rand()}, '1, int'(v[2:0]) + 1);
			do_read(v[3], addr, int'(v[6:4]) + 1);
			// the other port stays blocked during each held response
			fork
				do_read(1'b0, a_if, int'(v[9:7]) + 1);
				do_read(1'b1, a_d, int'(v[12:10]) + 1);
			join
		end
	endtask

	initial begin
		rst = 1'b1;
		if_ar = '0;
		if_arvalid = 1'b0;
		if_rready = 1'b0;
		d_ar = '0;
		d_arvalid = 1'b0;
		d_rready = 1'b0;
		d_aw = '0;
		d_awvalid = 1'b0;
		d_w = '0;
		d_wvalid = 1'b0;
		d_bready = 1'b0;
		lcg_state = 32'd47626;
		errors = 0;
		checks = 0;
		reset_dut();
		fill_memory();
		test_write_read();
		test_strobes();
		test_out_of_range();
		test_simultaneous();
		test_backpressure();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- axi_sram_subsys.f
hdl/mem_pkg.sv
hdl/axi_sram.sv
hdl/axi_read_arbiter.sv
hdl/axi_sram_subsys_top.sv
bench/axi_sram_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing
TOP ?= axi_sram_subsys_tb
FILE_LIST ?= axi_sram_subsys.f
OBJ_DIR ?= obj_dir
PASS_MSG = All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
